//--- uart_calc_top.f
hw/uart_pkg.sv
hw/calc_pkg.sv
hw/sync_fifo.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/calc_parser.sv
hw/reply_sequencer.sv
hw/uart_calc_top.sv
verif/uart_calc_assert.sv
verif/tb_uart_calc.sv

//--- Bender.yml
package:
  name: uart_calc

sources:
  - files:
      - hw/uart_pkg.sv
      - hw/calc_pkg.sv
      - hw/sync_fifo.sv
      - hw/uart_rx.sv
      - hw/uart_tx.sv
      - hw/calc_parser.sv
      - hw/reply_sequencer.sv
      - hw/uart_calc_top.sv
  - target: test
    files:
      - verif/uart_calc_assert.sv
      - verif/tb_uart_calc.sv

//--- verif/tb_uart_calc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart_calc
    import uart_pkg::*, calc_pkg::*;
();

    localparam int CLKS_PER_BIT = 16;
    localparam int N_DIRECTED   = 19;
    localparam int N_FRAMED     = 4;       // hand-made run around a bad stop bit
    localparam int N_RANDOM     = 240;
    localparam int N_FRAMES     = N_DIRECTED + N_FRAMED + N_RANDOM;
    // each frame costs its input plus idle gap (11 bits), two replies and 2 bits slack
    localparam int TIMEOUT_CYCLES = N_FRAMES * (11 + 2 * 10 + 2) * CLKS_PER_BIT + 2000;
    localparam logic [31:0] SEED = 32'hd9badd10;

    // "39+" "25-" "7x" "1"ESC "??+" "0?-" "12a"
    localparam uart_byte_t DIRECTED [N_DIRECTED] = '{
        8'h33, 8'h39, CHAR_PLUS, 8'h32, 8'h35, CHAR_MINUS, 8'h37, 8'h78,
        8'h31, CHAR_ESC, 8'h3F, 8'h3F, CHAR_PLUS, 8'h30, 8'h3F, CHAR_MINUS,
        8'h31, 8'h32, 8'h61
    };

    logic           CLKOP = 1'b0;
    logic           rst = 1'b1;
    logic           serial_in = 1'b1;      // idle line
    logic           serial_out;
    calc_result_t   led;

    // reference model state
    uart_byte_t     exp_q [$];             // characters still owed by the DUT
    calc_result_t   exp_led = '0;
    int             grp = 0;               // chars of current group
    nibble_t        opa;
    nibble_t        opb;

    string          cur_test = "reset";
    int             n_frames = 0;
    int             n_rx = 0;
    int             cycle_cnt = 0;

    uart_calc_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (4)
    ) u_dut (
        .CLKOP         (CLKOP),
        .i_rst         (rst),
        .i_serial_data (serial_in),
        .o_serial_data (serial_out),
        .o_led         (led)
    );

    always #4 CLKOP = ~CLKOP;              // 125 MHz

    // ------------------------------------------------------------------------
    // reporting and compare
    // ------------------------------------------------------------------------
    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp) fail_now($sformatf("error: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_result(input string name, input calc_result_t exp,
                                input calc_result_t act);
        if (act !== exp) fail_now($sformatf("error: %s expected %h actual %h", name, exp, act));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // weighted mix of digits, operators, printable junk, esc and broken frames
    task automatic pick_char(input logic [31:0] r, output uart_byte_t ch, output logic good);
        good = 1'b1;
        case (r[3:0])
            4'd7, 4'd8:   ch = CHAR_PLUS;
            4'd9, 4'd10:  ch = CHAR_MINUS;
            4'd11, 4'd12: ch = 8'h20 + (r[15:8] % 8'd95);  // ' '..'~'
            4'd13:        ch = CHAR_ESC;
            4'd14: begin
                ch   = r[23:16];
                good = 1'b0;                               // zero stop bit
            end
            default:      ch = {DIGIT_PREFIX, r[11:8]};
        endcase
    endtask

    // parser rules applied to one good character
    task automatic model_char(input uart_byte_t ch);
        logic digit;
        int   diff;
        digit = (ch[7:4] == DIGIT_PREFIX);
        if (ch == CHAR_ESC) begin
            grp = 0;                       // resync without echo
            return;
        end
        exp_q.push_back(ch);
        if (grp == 0 || grp == 1) begin
            if (grp == 0) opa = ch[3:0];
            else opb = ch[3:0];
            grp = digit ? grp + 1 : 0;
        end else begin
            if (ch == CHAR_PLUS || ch == CHAR_MINUS) begin
                diff = (ch == CHAR_PLUS) ? int'(opa) + int'(opb) : int'(opa) - int'(opb);
                exp_led = diff[4:0];       // 5 bit wrap leaves the borrow on top
                exp_q.push_back(RESULT_BASE + 8'(exp_led));
            end
            grp = 0;
        end
    endtask

    // start, 8 data lsb first, stop, then one idle bit
    task automatic send_frame(input uart_byte_t ch, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, ch, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge CLKOP);
            #1;
            serial_in = (i < 10) ? bits[i] : 1'b1;
            repeat (CLKS_PER_BIT - 1) @(posedge CLKOP);
        end
    endtask

    task automatic run_frame(input uart_byte_t ch, input logic good, input string tag);
        cur_test = $sformatf("%s frame %0d", tag, n_frames);
        n_frames++;
        if (good) model_char(ch);
        send_frame(ch, good);
        while (exp_q.size() != 0) @(posedge CLKOP);   // pacing keeps the queues shallow
        repeat (2) @(posedge CLKOP);
        #1;
        check_result({cur_test, " led"}, exp_led, led);
    endtask

    // ------------------------------------------------------------------------
    // output monitor with mid-bit sampling
    // ------------------------------------------------------------------------
    initial begin : monitor
        uart_byte_t ch;
        forever begin
            @(posedge CLKOP);
            if (!rst && serial_out === 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(posedge CLKOP);   // middle of start
                if (serial_out !== 1'b0) fail_now("glitch instead of a start bit on output");
                for (int i = 0; i < DATA_BITS; i++) begin
                    repeat (CLKS_PER_BIT) @(posedge CLKOP);
                    ch[i] = serial_out;
                end
                repeat (CLKS_PER_BIT) @(posedge CLKOP);
                if (serial_out !== 1'b1) fail_now("output frame has no stop bit");
                if (exp_q.size() == 0) begin
                    fail_now($sformatf("unexpected output character %h during %s",
                                       ch, cur_test));
                end
                check_byte($sformatf("%s output %0d", cur_test, n_rx), exp_q.pop_front(), ch);
                n_rx++;
            end
        end
    end

    // bound checkers count their own assertion failures
    always @(posedge CLKOP) begin
        if (u_dut.u_seq.u_seq_assert.n_fail != 0 || u_dut.u_tx.u_tx_assert.n_fail != 0) begin
            fail_now("a bound assertion on the sequencer or transmitter failed");
        end
    end

    always @(posedge CLKOP) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) fail_now("timeout, DUT stopped answering");
    end

    initial begin : stimulus
        uart_byte_t  ch;
        logic        good;
        logic [31:0] rnd;
        serial_in = 1'b1;
        rst       = 1'b1;
        repeat (5) @(posedge CLKOP);
        #1;
        rst = 1'b0;
        // quiet line and dark leds until the first frame
        repeat (4 * CLKS_PER_BIT) begin
            @(posedge CLKOP);
            #1;
            if (serial_out !== 1'b1) fail_now("o_serial_data left idle after reset");
            check_result("after reset", '0, led);
        end
        for (int k = 0; k < N_DIRECTED; k++) run_frame(DIRECTED[k], 1'b1, "directed");
        // a broken '9' between operands must leave 8 + 1 intact
        run_frame(8'h38, 1'b1, "framing");
        run_frame(8'h39, 1'b0, "framing");
        run_frame(8'h31, 1'b1, "framing");
        run_frame(CHAR_PLUS, 1'b1, "framing");
        rnd = SEED;
        for (int k = 0; k < N_RANDOM; k++) begin
            rnd = xorshift(rnd);
            pick_char(rnd, ch, good);
            run_frame(ch, good, "random");
        end
        cur_test = "drain";
        repeat (20 * CLKS_PER_BIT) @(posedge CLKOP);  // nothing extra may show up
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/uart_calc_assert.sv
`timescale 1ns/1ns
`default_nettype none

module uart_calc_assert
    import uart_pkg::*;
#(
    parameter bit SEQ_SIDE = 1'b1           // sequencer checks rather than the tx line check
) (
    input  wire             CLKOP,
    input  wire             i_rst,
    input  wire uart_byte_t i_data,         // byte on offer to the tx
    input  wire             i_valid,
    input  wire             i_ready,
    input  wire             i_echo_push,
    input  wire             i_echo_full,
    input  wire             i_result_push,
    input  wire             i_result_full,
    input  wire             i_tx_idle,
    input  wire             i_serial_data
);

    int unsigned n_fail = 0;                // failed assertions in this instance

    generate
        if (SEQ_SIDE) begin : g_seq
            // offered byte frozen until the tx takes it
            a_hold_data: assert property (@(posedge CLKOP) disable iff (i_rst)
                (i_valid && !i_ready) |=> $stable(i_data))
                else begin
                    n_fail++;
                    $error("tx byte changed while waiting for ready");
                end

            // pacing keeps both queues shallow
            a_echo_room: assert property (@(posedge CLKOP) disable iff (i_rst)
                !(i_echo_push && i_echo_full))
                else begin
                    n_fail++;
                    $error("echo pushed into full queue");
                end

            a_result_room: assert property (@(posedge CLKOP) disable iff (i_rst)
                !(i_result_push && i_result_full))
                else begin
                    n_fail++;
                    $error("result pushed into full queue");
                end
        end else begin : g_tx
            a_idle_high: assert property (@(posedge CLKOP) disable iff (i_rst)
                i_tx_idle |-> i_serial_data)
                else begin
                    n_fail++;
                    $error("serial line low while transmitter idle");
                end
        end
    endgenerate

endmodule

// sequencer offer and its two queues
bind reply_sequencer uart_calc_assert #(.SEQ_SIDE(1'b1)) u_seq_assert (
    .CLKOP         (CLKOP),
    .i_rst         (i_rst),
    .i_data        (o_tx_data),
    .i_valid       (o_tx_valid),
    .i_ready       (i_tx_ready),
    .i_echo_push   (i_echo_valid),
    .i_echo_full   (!echo_q_ready),
    .i_result_push (i_result_valid),
    .i_result_full (!result_q_ready),
    .i_tx_idle     (1'b0),
    .i_serial_data (1'b1)
);

// ready doubles as the tx idle flag
bind uart_tx uart_calc_assert #(.SEQ_SIDE(1'b0)) u_tx_assert (
    .CLKOP         (CLKOP),
    .i_rst         (i_rst),
    .i_data        ('0),
    .i_valid       (1'b0),
    .i_ready       (1'b0),
    .i_echo_push   (1'b0),
    .i_echo_full   (1'b0),
    .i_result_push (1'b0),
    .i_result_full (1'b0),
    .i_tx_idle     (o_ready),
    .i_serial_data (o_serial_data)
);

`default_nettype wire

//--- hw/uart_calc_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_calc_top
    import uart_pkg::*, calc_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16,    // baud = CLKOP / CLKS_PER_BIT
    parameter int FIFO_DEPTH   = 4
) (
    input  wire         CLKOP,
    input  wire         i_rst,
    input  wire         i_serial_data,
    output logic        o_serial_data,
    output calc_result_t o_led
);

    uart_byte_t     rx_data;
    logic           rx_valid;
    uart_byte_t     echo;
    logic           echo_valid;
    calc_result_t   result;
    logic           result_valid;
    uart_byte_t     tx_data;
    logic           tx_valid;
    logic           tx_ready;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .CLKOP         (CLKOP),
        .i_rst         (i_rst),
        .i_serial_data (i_serial_data),
        .o_data        (rx_data),
        .o_valid       (rx_valid)
    );

    calc_parser u_parser (
        .CLKOP          (CLKOP),
        .i_rst          (i_rst),
        .i_data         (rx_data),
        .i_valid        (rx_valid),
        .o_echo         (echo),
        .o_echo_valid   (echo_valid),
        .o_result       (result),
        .o_result_valid (result_valid),
        .o_led          (o_led)
    );

    reply_sequencer #(.FIFO_DEPTH(FIFO_DEPTH)) u_seq (
        .CLKOP          (CLKOP),
        .i_rst          (i_rst),
        .i_echo         (echo),
        .i_echo_valid   (echo_valid),
        .i_result       (result),
        .i_result_valid (result_valid),
        .o_tx_data      (tx_data),
        .o_tx_valid     (tx_valid),
        .i_tx_ready     (tx_ready)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .CLKOP         (CLKOP),
        .i_rst         (i_rst),
        .i_data        (tx_data),
        .i_valid       (tx_valid),
        .o_ready       (tx_ready),
        .o_serial_data (o_serial_data)
    );

endmodule

`default_nettype wire

//--- hw/reply_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module reply_sequencer
    import uart_pkg::*, calc_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire         CLKOP,
    input  wire         i_rst,
    input  wire uart_byte_t i_echo,
    input  wire         i_echo_valid,
    input  wire calc_result_t i_result,
    input  wire         i_result_valid,
    output uart_byte_t  o_tx_data,
    output logic        o_tx_valid,
    input  wire         i_tx_ready
);

    uart_byte_t     echo_head;
    logic           echo_head_valid;
    logic           echo_q_ready;       // echo queue not full
    calc_result_t   result_head;
    logic           result_head_valid;
    logic           result_q_ready;
    logic           lock_result;        // result already on offer
    logic           sel_echo;

    sync_fifo #(.T(uart_byte_t), .FIFO_DEPTH(FIFO_DEPTH)) u_echo_q (
        .CLKOP   (CLKOP),
        .i_rst   (i_rst),
        .i_data  (i_echo),
        .i_valid (i_echo_valid),
        .o_ready (echo_q_ready),
        .o_data  (echo_head),
        .o_valid (echo_head_valid),
        .i_ready (i_tx_ready && sel_echo)
    );

    sync_fifo #(.T(calc_result_t), .FIFO_DEPTH(FIFO_DEPTH)) u_result_q (
        .CLKOP   (CLKOP),
        .i_rst   (i_rst),
        .i_data  (i_result),
        .i_valid (i_result_valid),
        .o_ready (result_q_ready),
        .o_data  (result_head),
        .o_valid (result_head_valid),
        .i_ready (i_tx_ready && !sel_echo)
    );

    // echo first, but a result already waiting at the tx stays put
    assign sel_echo   = echo_head_valid && !lock_result;
    assign o_tx_valid = echo_head_valid || result_head_valid;
    assign o_tx_data  = sel_echo ? echo_head : RESULT_BASE + {3'b000, result_head};

    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            lock_result <= 1'b0;
        end else begin
            lock_result <= !sel_echo && result_head_valid && !i_tx_ready;
        end
    end

endmodule

`default_nettype wire

//--- hw/calc_parser.sv
`timescale 1ns/1ns
`default_nettype none

module calc_parser
    import uart_pkg::*, calc_pkg::*;
(
    input  wire         CLKOP,
    input  wire         i_rst,
    input  wire uart_byte_t i_data,
    input  wire         i_valid,
    output uart_byte_t  o_echo,
    output logic        o_echo_valid,
    output calc_result_t o_result,
    output logic        o_result_valid,
    output calc_result_t o_led
);

    logic [1:0]     grp_cnt;        // chars seen in this group, 0..2
    nibble_t        op_a;
    nibble_t        op_b;
    calc_op_e       op;
    calc_result_t   alu_out;
    calc_result_t   result_q;       // last answer, also on the leds
    logic           is_digit;
    logic           is_esc;
    logic           is_op;
    logic           take_a;
    logic           take_b;
    logic           do_calc;

    // ------------------------------------------------------------------------
    // character decode
    // ------------------------------------------------------------------------
    assign is_digit = (i_data[7:4] == DIGIT_PREFIX);
    assign is_esc   = (i_data == CHAR_ESC);
    assign is_op    = (i_data == CHAR_PLUS) || (i_data == CHAR_MINUS);
    assign op       = (i_data == CHAR_MINUS) ? OP_SUB : OP_ADD;

    assign take_a  = i_valid && !is_esc && is_digit && (grp_cnt == 2'd0);
    assign take_b  = i_valid && !is_esc && is_digit && (grp_cnt == 2'd1);
    assign do_calc = i_valid && !is_esc && is_op    && (grp_cnt == 2'd2);

    // 5 bit wrap, borrow lands in the carry bit
    always_comb begin
        case (op)
            OP_SUB:  alu_out = {1'b0, op_a} - {1'b0, op_b};
            default: alu_out = {1'b0, op_a} + {1'b0, op_b};
        endcase
    end

    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            grp_cnt        <= 2'd0;
            o_echo_valid   <= 1'b0;
            o_result_valid <= 1'b0;
            result_q       <= '0;
        end else begin
            o_echo_valid   <= i_valid && !is_esc;   // esc swallowed
            o_result_valid <= do_calc;
            if (do_calc) result_q <= alu_out;
            if (i_valid) begin
                if (is_esc || grp_cnt == 2'd2 || !is_digit) begin
                    grp_cnt <= 2'd0;    // third char or junk ends the group
                end else begin
                    grp_cnt <= grp_cnt + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge CLKOP) begin
        if (i_valid) o_echo <= i_data;
        if (take_a)  op_a <= i_data[3:0];
        if (take_b)  op_b <= i_data[3:0];
    end

    assign o_result = result_q;
    assign o_led    = result_q;

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire         CLKOP,
    input  wire         i_rst,
    input  wire uart_byte_t i_data,
    input  wire         i_valid,
    output logic        o_ready,        // idle only
    output logic        o_serial_data
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(DATA_BITS);

    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_BITS - 1);

    tx_state_e          state;
    logic [CNT_W-1:0]   clk_cnt;
    logic [BIT_W-1:0]   bit_idx;
    logic               bit_done;   // last cycle of the current bit
    uart_byte_t         shift_q;

    assign o_ready  = (state == TX_IDLE);
    assign bit_done = (clk_cnt == FULL_CNT);

    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            state         <= TX_IDLE;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            o_serial_data <= 1'b1;
        end else begin
            clk_cnt <= (state == TX_IDLE || bit_done) ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE: if (i_valid) begin
                    state         <= TX_START;
                    bit_idx       <= '0;
                    o_serial_data <= 1'b0;      // start bit next cycle
                end
                TX_START: if (bit_done) begin
                    state         <= TX_DATA;
                    o_serial_data <= shift_q[0];
                end
                TX_DATA: if (bit_done) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == LAST_BIT) begin
                        state         <= TX_STOP;
                        o_serial_data <= 1'b1;
                    end else begin
                        o_serial_data <= shift_q[1];  // bit about to shift down
                    end
                end
                TX_STOP: if (bit_done) state <= TX_IDLE;   // ready again after 10 bits
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLKOP) begin
        if (o_ready && i_valid) begin
            shift_q <= i_data;
        end else if (state == TX_DATA && bit_done) begin
            shift_q <= {1'b0, shift_q[DATA_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire         CLKOP,
    input  wire         i_rst,
    input  wire         i_serial_data,  // idle high
    output uart_byte_t  o_data,
    output logic        o_valid         // one cycle, good frames only
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(DATA_BITS);

    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_BITS - 1);

    rx_state_e          state;
    logic [CNT_W-1:0]   clk_cnt;    // cycles inside current bit
    logic [BIT_W-1:0]   bit_idx;
    logic [1:0]         sync_q;     // metastability chain
    logic               rx_bit;
    logic               sample_en;
    uart_byte_t         shift_q;

    assign rx_bit    = sync_q[1];
    assign sample_en = (state == RX_DATA) && (clk_cnt == FULL_CNT);
    assign o_data    = shift_q;     // holds until the next frame shifts in

    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            sync_q <= 2'b11;        // line idles high
        end else begin
            sync_q <= {sync_q[0], i_serial_data};
        end
    end

    // ------------------------------------------------------------------------
    // frame FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_bit) state <= RX_START;    // falling edge
                end
                RX_START: begin
                    if (clk_cnt == HALF_CNT) begin
                        clk_cnt <= '0;
                        // high again at mid-bit means a glitch
                        state   <= rx_bit ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == FULL_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == FULL_CNT) begin
                        o_valid <= rx_bit;  // zero stop bit, frame dropped
                        state   <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge CLKOP) begin
        if (sample_en) shift_q <= {rx_bit, shift_q[DATA_BITS-1:1]};
    end

endmodule

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter type T          = logic [7:0],
    parameter int  FIFO_DEPTH = 4
) (
    input  wire     CLKOP,
    input  wire     i_rst,
    input  wire T   i_data,
    input  wire     i_valid,
    output logic    o_ready,    // not full
    output T        o_data,
    output logic    o_valid,    // not empty
    input  wire     i_ready
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

    T                   mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    assign o_ready = (count != FULL_CNT);
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];       // head, stable until popped
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;

    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither
            endcase
        end
    end

    always_ff @(posedge CLKOP) begin
        if (push) mem[wr_ptr] <= i_data;
    end

endmodule

`default_nettype wire

//--- hw/calc_pkg.sv
`default_nettype none

// ------------------------------------------------------------------------
// calculator operands, results and the command characters
// ------------------------------------------------------------------------
package calc_pkg;

    typedef logic [3:0] nibble_t;   // one decimal-ish operand

    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1               // first minus second
    } calc_op_e;

    // 5 bit two's complement view of the answer
    typedef struct packed {
        logic    carry;             // carry out, or borrow on subtract
        nibble_t sum;
    } calc_result_t;

    // digit test looks only at the upper nibble, so '0'..'?' all count
    localparam nibble_t DIGIT_PREFIX = 4'h3;

    localparam logic [7:0] CHAR_PLUS  = 8'h2B;  // '+'
    localparam logic [7:0] CHAR_MINUS = 8'h2D;  // '-'
    localparam logic [7:0] CHAR_ESC   = 8'h1B;  // resync, never echoed

    // result r goes out as '@' + r, range '@'..'_'
    localparam logic [7:0] RESULT_BASE = 8'h40;

endpackage

`default_nettype wire

//--- hw/uart_pkg.sv
`default_nettype none

// ------------------------------------------------------------------------
// serial line types shared by the receiver, transmitter and sequencer
// ------------------------------------------------------------------------
package uart_pkg;

    localparam int DATA_BITS = 8;               // 8N1 only

    typedef logic [DATA_BITS-1:0] uart_byte_t;  // one character on the line

    // receiver walk through one frame
    typedef enum logic [1:0] {
        RX_IDLE  = 2'b00,   // line high, waiting for falling edge
        RX_START = 2'b01,   // half bit, confirm start
        RX_DATA  = 2'b10,   // sample data bits at mid-bit
        RX_STOP  = 2'b11    // framing check
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'b00,   // ready high, line high
        TX_START = 2'b01,
        TX_DATA  = 2'b10,   // lsb first
        TX_STOP  = 2'b11
    } tx_state_e;

endpackage

`default_nettype wire
